// ==== sim.f ====
+incdir+include
verilog/usiBusPkg.sv
verilog/boardIoPkg.sv
verilog/usiBus.sv
verilog/gpioBlock.sv
verilog/sysTimerBlock.sv
verilog/boardCtrlTop.sv
sim/tbBoardCtrlTop.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tbBoardCtrlTop
FILELIST = sim.f
OBJDIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== include/tbUsiTasks.svh ====
`ifndef TB_USI_TASKS_SVH
`define TB_USI_TASKS_SVH

// Included inside the testbench module after iMCLK, reqValid, reqReady, req,
// rspValid, rspReady and rsp are declared

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsrStep(input logic [15:0] state);
	return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

task automatic failTest(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
	$display("ERROR %s expected %h actual %h", name, expVal, actVal);
	$display("TESTS FAILED");
	$fatal(1, "mismatch in %s", name);
endtask

task automatic checkUsiRsp(input string name, input usiRspT expRsp, input usiRspT actRsp);
	if (actRsp !== expRsp)
		failTest(name, expRsp.rd, actRsp.rd);
endtask

task automatic checkLed(input string name, input logic [lpLedWidth-1:0] expLed,
		input logic [lpLedWidth-1:0] actLed);
	if (actLed !== expLed)
		failTest(name, 32'(expLed), 32'(actLed));
endtask

// One full transaction, all sampling on the falling edge
task automatic usiXfer(input string name, input logic wr, input logic [31:0] adrs,
		input logic [31:0] wd, input int holdCycles, output usiRspT rxRsp);
	usiRspT heldRsp;
	@(negedge iMCLK);
	while (!reqReady)
		@(negedge iMCLK);
	reqValid = 1'b1;
	req.wr = wr;
	req.adrs.raw = adrs;
	req.wd = wd;
	// Accepted on the rising edge in between
	@(negedge iMCLK);
	reqValid = 1'b0;
	if (!rspValid)
		failTest(name, 32'd1, 32'(rspValid));
	heldRsp = rsp;
	// Back-pressure, response frozen and no new request taken
	repeat (holdCycles)
	begin
		@(negedge iMCLK);
		if (rsp !== heldRsp)
			failTest(name, heldRsp.rd, rsp.rd);
		if (reqReady || !rspValid)
			failTest(name, 32'd0, 32'(reqReady));
	end
	rspReady = 1'b1;
	rxRsp = rsp;
	@(negedge iMCLK);
	rspReady = 1'b0;
	// Exactly one response per request
	if (rspValid)
		failTest(name, 32'd0, 32'(rspValid));
endtask

`endif

// ==== sim/tbBoardCtrlTop.sv ====
`default_nettype none

module tbBoardCtrlTop
	import usiBusPkg::*, boardIoPkg::*;
();

	typedef struct {
		string name;
		logic wr;
		logic [31:0] adrs;
		logic [31:0] wd;
		usiRspT expRsp;
	} tblEntryT;

	localparam int lpTblLen = 14;
	// Switch levels driven from the start
	localparam logic [lpPushSwWidth-1:0] lpPushInit = 7'h5A;
	localparam logic [lpDipSwWidth-1:0] lpDipInit = 2'b10;
	localparam logic [31:0] lpTimerLoad = 32'h8000_0000;

	logic iMCLK;
	logic qnARST;
	logic reqValid;
	logic reqReady;
	usiReqT req;
	logic rspValid;
	logic rspReady;
	usiRspT rsp;
	logic [lpPushSwWidth-1:0] pushSw;
	logic [lpDipSwWidth-1:0] dipSw;
	logic [lpLedWidth-1:0] led;

	tblEntryT tbl [lpTblLen];
	logic [15:0] lfsrState = 16'd34874;
	int cycleCnt = 0;
	int startCnt;
	usiRspT rxRsp;
	logic ledFirst;
	logic toggled;

	`include "tbUsiTasks.svh"

	boardCtrlTop i_dut (
		.iMCLK(iMCLK), .qnARST(qnARST),
		.reqValid(reqValid), .reqReady(reqReady), .req(req),
		.rspValid(rspValid), .rspReady(rspReady), .rsp(rsp),
		.pushSw(pushSw), .dipSw(dipSw), .led(led)
	);

	//--------------------------------------------------------------------------
	// Clock, cycle count, watchdog
	//--------------------------------------------------------------------------
	always #2 iMCLK = ~iMCLK;

	always @(posedge iMCLK)
		cycleCnt <= cycleCnt + 1;

	initial
	begin
		repeat (lpTblLen * 20 + 200) @(posedge iMCLK);
		$display("TESTS FAILED");
		$fatal(1, "watchdog expired before the bus tests finished");
	end

	// Back-pressure length 0..3 with one LFSR step per bit
	function automatic int drawHold();
		logic [1:0] bits;
		for (int b = 0; b < 2; b++)
		begin
			lfsrState = lfsrStep(lfsrState);
			bits[b] = lfsrState[0];
		end
		return int'(bits);
	endfunction

	task automatic setEntry(input int idx, input string name, input logic wr,
			input logic [31:0] adrs, input logic [31:0] wd, input logic [31:0] expRd);
		tbl[idx].name = name;
		tbl[idx].wr = wr;
		tbl[idx].adrs = adrs;
		tbl[idx].wd = wd;
		tbl[idx].expRsp.rd = expRd;
	endtask

	task automatic checkCntRange(input string name, input logic [31:0] lo,
			input logic [31:0] hi, input usiRspT actRsp);
		if (actRsp.rd <= lo || actRsp.rd > hi)
		begin
			$display("ERROR %s expected %h..%h actual %h", name, lo + 32'd1, hi, actRsp.rd);
			$display("TESTS FAILED");
			$fatal(1, "timer value out of range in %s", name);
		end
	endtask

	task automatic fillTable();
		// Block number sits at bits 18..16
		// Writes answer with zero
		setEntry(0, "ledWr", 1'b1, 32'h0000_0000, 32'h0000_00A5, 32'h0);
		setEntry(1, "ledRd", 1'b0, 32'h0000_0000, 32'h0, 32'h5);
		setEntry(2, "altRd", 1'b0, 32'h0000_0004, 32'h0, 32'h0);
		setEntry(3, "swRd", 1'b0, 32'h0000_0008, 32'h0, 32'({lpPushInit, lpDipInit}));
		setEntry(4, "gpioBadRd", 1'b0, 32'h0000_000C, 32'h0, 32'h0);
		setEntry(5, "blk1Wr", 1'b1, 32'h0001_0000, 32'hFFFF_FFFF, 32'h0);
		setEntry(6, "blk1Rd", 1'b0, 32'h0001_0000, 32'h0, 32'h0);
		setEntry(7, "blk2Rd", 1'b0, 32'h0002_0000, 32'h0, 32'h0);
		setEntry(8, "blk3Rd", 1'b0, 32'h0003_0004, 32'h0, 32'h0);
		setEntry(9, "blk5Rd", 1'b0, 32'h0005_0000, 32'h0, 32'h0);
		setEntry(10, "blk6Wr", 1'b1, 32'h0006_0008, 32'h1234_5678, 32'h0);
		setEntry(11, "blk6Rd", 1'b0, 32'h0006_0008, 32'h0, 32'h0);
		setEntry(12, "blk7Rd", 1'b0, 32'h0007_0000, 32'h0, 32'h0);
		// Empty slot writes must not reach the GPIO
		setEntry(13, "ledRdAgain", 1'b0, 32'h0000_0000, 32'h0, 32'h5);
	endtask

	//--------------------------------------------------------------------------
	// Stimulus
	//--------------------------------------------------------------------------
	initial
	begin
		iMCLK = 1'b0;
		qnARST = 1'b0;
		reqValid = 1'b0;
		req = '0;
		rspReady = 1'b0;
		pushSw = lpPushInit;
		dipSw = lpDipInit;
		fillTable();
		repeat (3) @(negedge iMCLK);
		qnARST = 1'b1;
		// Internal reset release plus switch sync
		repeat (4) @(negedge iMCLK);

		for (int i = 0; i < lpTblLen; i++)
		begin
			usiXfer(tbl[i].name, tbl[i].wr, tbl[i].adrs, tbl[i].wd, drawHold(), rxRsp);
			checkUsiRsp(tbl[i].name, tbl[i].expRsp, rxRsp);
		end
		checkLed("ledPort", 4'h5, led);

		// Switch change visible after three cycles
		@(negedge iMCLK);
		pushSw = 7'h23;
		dipSw = 2'b01;
		repeat (3) @(negedge iMCLK);
		usiXfer("swRd2", 1'b0, 32'h0000_0008, 32'h0, drawHold(), rxRsp);
		checkUsiRsp("swRd2", 32'({7'h23, 2'b01}), rxRsp);

		// Timer load then a later read
		startCnt = cycleCnt;
		usiXfer("timerWr", 1'b1, 32'h0004_0000, lpTimerLoad, drawHold(), rxRsp);
		checkUsiRsp("timerWr", 32'h0, rxRsp);
		usiXfer("timerRd", 1'b0, 32'h0004_0000, 32'h0, drawHold(), rxRsp);
		checkCntRange("timerRd", lpTimerLoad, lpTimerLoad + 32'(cycleCnt - startCnt), rxRsp);

		// LED 0 on heartbeat and the rest from data 0xA
		usiXfer("ledWrA", 1'b1, 32'h0000_0000, 32'h0000_000A, drawHold(), rxRsp);
		checkUsiRsp("ledWrA", 32'h0, rxRsp);
		usiXfer("altWr", 1'b1, 32'h0000_0004, 32'h0000_0001, drawHold(), rxRsp);
		checkUsiRsp("altWr", 32'h0, rxRsp);
		toggled = 1'b0;
		ledFirst = led[0];
		for (int c = 0; c < 2 * lpHeartbeatHalf && !toggled; c++)
		begin
			@(negedge iMCLK);
			checkLed("ledAltOthers", 4'hA & 4'hE, led & 4'hE);
			if (led[0] !== ledFirst)
				toggled = 1'b1;
		end
		if (!toggled)
		begin
			$display("TESTS FAILED");
			$fatal(1, "LED 0 never followed the heartbeat");
		end
		else
		begin
			$display("TESTS PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/boardCtrlTop.sv ====
`default_nettype none

module boardCtrlTop
	import usiBusPkg::*, boardIoPkg::*;
(
	input wire logic iMCLK,
	input wire logic qnARST,
	// CSR bus master port
	input wire logic reqValid,
	output logic reqReady,
	input wire usiReqT req,
	output logic rspValid,
	input wire logic rspReady,
	output usiRspT rsp,
	// User I/F
	input wire logic [lpPushSwWidth-1:0] pushSw,
	input wire logic [lpDipSwWidth-1:0] dipSw,
	output logic [lpLedWidth-1:0] led
);

	logic rRstMeta;
	logic rnMRST;
	usiSlvReqT gpioReq;
	usiSlvReqT timerReq;
	logic [lpUsiBusWidth-1:0] gpioRd;
	logic [lpUsiBusWidth-1:0] timerRd;
	logic heartbeat;
	swStatusT qSwStatus;

	//--------------------------------------------------------------------------
	// Reset synchronizer
	//--------------------------------------------------------------------------
	// Assert at once, release two edges later
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			rRstMeta <= 1'b0;
			rnMRST <= 1'b0;
		end
		else
		begin
			rRstMeta <= 1'b1;
			rnMRST <= rRstMeta;
		end
	end

	assign qSwStatus = '{pushSw: pushSw, dipSw: dipSw};

	//--------------------------------------------------------------------------
	// Bus and blocks
	//--------------------------------------------------------------------------
	usiBus i_usiBus (
		.iMCLK(iMCLK), .qnARST(rnMRST),
		.reqValid(reqValid), .reqReady(reqReady), .req(req),
		.rspValid(rspValid), .rspReady(rspReady), .rsp(rsp),
		.gpioReq(gpioReq), .timerReq(timerReq),
		.gpioRd(gpioRd), .timerRd(timerRd)
	);

	gpioBlock i_gpioBlock (
		.iMCLK(iMCLK), .qnARST(rnMRST),
		.slvReq(gpioReq), .rdData(gpioRd),
		.swIn(qSwStatus), .heartbeat(heartbeat), .led(led)
	);

	// Heartbeat goes straight to the LED alternate source
	sysTimerBlock i_sysTimerBlock (
		.iMCLK(iMCLK), .qnARST(rnMRST),
		.slvReq(timerReq), .rdData(timerRd),
		.heartbeat(heartbeat)
	);

endmodule

`default_nettype wire

// ==== verilog/sysTimerBlock.sv ====
`default_nettype none

module sysTimerBlock
	import usiBusPkg::*, boardIoPkg::*;
(
	input wire logic iMCLK,
	input wire logic qnARST,
	// CSR access
	input wire usiSlvReqT slvReq,
	output logic [lpUsiBusWidth-1:0] rdData,
	// Square wave for the LED alternate mode
	output logic heartbeat
);

	logic [lpUsiBusWidth-1:0] rCnt;
	logic [lpHeartbeatCntWidth-1:0] rDivCnt;
	logic qCntLoad;
	logic qDivWrap;

	//--------------------------------------------------------------------------
	// Free-running counter
	//--------------------------------------------------------------------------
	assign qCntLoad = slvReq.we && (slvReq.csrAdrs == lpTimerCntCsr);

	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
			rCnt <= '0;
		else if (qCntLoad)
			// Load wins over the increment
			rCnt <= slvReq.wd;
		else
			rCnt <= rCnt + 1'b1;
	end

	// Value as it stands in the access cycle
	always_comb
	begin
		if (slvReq.re && (slvReq.csrAdrs == lpTimerCntCsr))
			rdData = rCnt;
		else
			rdData = '0;
	end

	//--------------------------------------------------------------------------
	// Heartbeat divider
	//--------------------------------------------------------------------------
	// Independent of the counter, a load leaves the heartbeat alone
	assign qDivWrap = (rDivCnt == lpHeartbeatCntWidth'(lpHeartbeatHalf - 1));

	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			rDivCnt <= '0;
			heartbeat <= 1'b0;
		end
		else if (qDivWrap)
		begin
			rDivCnt <= '0;
			heartbeat <= !heartbeat;
		end
		else
			rDivCnt <= rDivCnt + 1'b1;
	end

	// Half period is never a single cycle
	hbRateChk: assert property (@(posedge iMCLK) disable iff (!qnARST)
		$changed(heartbeat) |=> !$changed(heartbeat));

endmodule

`default_nettype wire

// ==== verilog/gpioBlock.sv ====
`default_nettype none

module gpioBlock
	import usiBusPkg::*, boardIoPkg::*;
(
	input wire logic iMCLK,
	input wire logic qnARST,
	// CSR access
	input wire usiSlvReqT slvReq,
	output logic [lpUsiBusWidth-1:0] rdData,
	// Raw switch levels, not yet in the iMCLK domain
	input wire swStatusT swIn,
	// Alternate LED source
	input wire logic heartbeat,
	output logic [lpLedWidth-1:0] led
);

	logic [lpLedWidth-1:0] rLedData;
	// One bit per LED, set means heartbeat
	logic [lpLedWidth-1:0] rAltMask;
	swStatusT rSwMeta;
	swStatusT rSwSync;

	//--------------------------------------------------------------------------
	// CSR write
	//--------------------------------------------------------------------------
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			rLedData <= '0;
			rAltMask <= '0;
		end
		else if (slvReq.we)
		begin
			case (slvReq.csrAdrs)
				lpGpioLedCsr:	rLedData <= slvReq.wd[lpLedWidth-1:0];
				lpGpioAltCsr:	rAltMask <= slvReq.wd[lpLedWidth-1:0];
				// Switch CSR read only, others ignored
				default:		;
			endcase
		end
	end

	// Two flop synchronizer for the switches
	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
		begin
			rSwMeta <= '0;
			rSwSync <= '0;
		end
		else
		begin
			rSwMeta <= swIn;
			rSwSync <= rSwMeta;
		end
	end

	//--------------------------------------------------------------------------
	// CSR read, zero-extended
	//--------------------------------------------------------------------------
	always_comb
	begin
		rdData = '0;
		// Only drive under a read strobe
		if (slvReq.re)
		begin
			case (slvReq.csrAdrs)
				lpGpioLedCsr:	rdData[lpLedWidth-1:0] = rLedData;
				lpGpioAltCsr:	rdData[lpLedWidth-1:0] = rAltMask;
				lpGpioSwCsr:	rdData[$bits(swStatusT)-1:0] = rSwSync;
				default:		rdData = '0;
			endcase
		end
	end

	// Per-bit choice between heartbeat and data
	assign led = (rAltMask & {lpLedWidth{heartbeat}}) | (~rAltMask & rLedData);

	// Bus decode upstream never asks for both
	strobeChk: assert property (@(posedge iMCLK) disable iff (!qnARST)
		!(slvReq.we && slvReq.re));

endmodule

`default_nettype wire

// ==== verilog/usiBus.sv ====
`default_nettype none

module usiBus
	import usiBusPkg::*;
(
	input wire logic iMCLK,
	input wire logic qnARST,
	// Request channel from the master
	input wire logic reqValid,
	output logic reqReady,
	input wire usiReqT req,
	// Response channel to the master
	output logic rspValid,
	input wire logic rspReady,
	output usiRspT rsp,
	// Block strobes
	output usiSlvReqT gpioReq,
	output usiSlvReqT timerReq,
	// Block read words
	input wire logic [lpUsiBusWidth-1:0] gpioRd,
	input wire logic [lpUsiBusWidth-1:0] timerRd
);

	logic qAccept;
	logic qGpioSel;
	logic qTimerSel;
	logic [lpBlockAdrsWidth-1:0] qBlockNo;
	logic [lpUsiBusWidth-1:0] qRdSel;

	//--------------------------------------------------------------------------
	// Request acceptance
	//--------------------------------------------------------------------------
	// Single word in flight, so the slot opens only after the response left
	assign reqReady = !rspValid;
	assign qAccept = reqValid && reqReady;

	// Block decode, the only place the block number is looked at
	assign qBlockNo = req.adrs.fld.blockNo;
	assign qGpioSel = (qBlockNo == lpGpioAdrsMap);
	assign qTimerSel = (qBlockNo == lpSysTimerAdrsMap);

	always_comb
	begin
		// Enables live for the acceptance cycle only
		gpioReq.we = qAccept && req.wr && qGpioSel;
		gpioReq.re = qAccept && !req.wr && qGpioSel;
		gpioReq.csrAdrs = req.adrs.fld.csrAdrs;
		gpioReq.wd = req.wd;

		timerReq.we = qAccept && req.wr && qTimerSel;
		timerReq.re = qAccept && !req.wr && qTimerSel;
		timerReq.csrAdrs = req.adrs.fld.csrAdrs;
		timerReq.wd = req.wd;
	end

	//--------------------------------------------------------------------------
	// Read mux and held response
	//--------------------------------------------------------------------------
	always_comb
	begin
		case (qBlockNo)
			lpGpioAdrsMap:		qRdSel = gpioRd;
			lpSysTimerAdrsMap:	qRdSel = timerRd;
			// Empty slots
			default:			qRdSel = '0;
		endcase
	end

	always_ff @(posedge iMCLK, negedge qnARST)
	begin
		if (!qnARST)
			rspValid <= 1'b0;
		else if (qAccept)
			rspValid <= 1'b1;
		else if (rspReady)
			rspValid <= 1'b0;
	end

	// Captured once per request, then held through back-pressure
	always_ff @(posedge iMCLK)
	begin
		if (qAccept)
			rsp.rd <= req.wr ? '0 : qRdSel;
	end

	// Master sees a frozen response until it takes it
	rspHoldChk: assert property (@(posedge iMCLK) disable iff (!qnARST)
		(rspValid && !rspReady) |=> (rspValid && $stable(rsp)));

endmodule

`default_nettype wire

// ==== verilog/boardIoPkg.sv ====
`default_nettype none

package boardIoPkg;
	import usiBusPkg::*;

	// User I/F widths on the board
	localparam int lpLedWidth = 4;
	localparam int lpPushSwWidth = 7;
	localparam int lpDipSwWidth = 2;

	// Heartbeat toggles every 16 cycles of iMCLK
	localparam int lpHeartbeatHalf = 16;
	localparam int lpHeartbeatCntWidth = $clog2(lpHeartbeatHalf);

	// GPIO CSR offsets
	localparam logic [lpCsrAdrsWidth-1:0] lpGpioLedCsr = 16'h0;
	localparam logic [lpCsrAdrsWidth-1:0] lpGpioAltCsr = 16'h4;
	localparam logic [lpCsrAdrsWidth-1:0] lpGpioSwCsr = 16'h8;
	// Timer CSR offsets
	localparam logic [lpCsrAdrsWidth-1:0] lpTimerCntCsr = 16'h0;

	// Switch levels as one word, push switches on top
	typedef struct packed {
		logic [lpPushSwWidth-1:0] pushSw;
		logic [lpDipSwWidth-1:0] dipSw;
	} swStatusT;

endpackage

`default_nettype wire

// ==== verilog/usiBusPkg.sv ====
`default_nettype none

package usiBusPkg;

	//--------------------------------------------------------------------------
	// Bus geometry and block address map
	//--------------------------------------------------------------------------
	// Shared width of data and address words
	localparam int lpUsiBusWidth = 32;
	// Block number field, eight slots
	localparam int lpBlockAdrsWidth = 3;
	// CSR offset inside one block
	localparam int lpCsrAdrsWidth = 16;

	// Slot numbers of the blocks that are present
	// Slots 1, 2, 3, 5, 6, 7 belong to blocks not fitted here
	localparam logic [lpBlockAdrsWidth-1:0] lpGpioAdrsMap = 3'd0;
	localparam logic [lpBlockAdrsWidth-1:0] lpSysTimerAdrsMap = 3'd4;

	//--------------------------------------------------------------------------
	// Address word, raw or split into fields
	//--------------------------------------------------------------------------
	typedef struct packed {
		logic [lpUsiBusWidth-lpBlockAdrsWidth-lpCsrAdrsWidth-1:0] rsvd;
		logic [lpBlockAdrsWidth-1:0] blockNo;
		logic [lpCsrAdrsWidth-1:0] csrAdrs;
	} usiAdrsFieldT;

	typedef union packed {
		logic [lpUsiBusWidth-1:0] raw;
		usiAdrsFieldT fld;
	} usiAdrsU;

	// Master request, 65 bits
	typedef struct packed {
		logic wr;
		usiAdrsU adrs;
		logic [lpUsiBusWidth-1:0] wd;
	} usiReqT;

	// Response, read data only
	typedef struct packed {
		logic [lpUsiBusWidth-1:0] rd;
	} usiRspT;

	// Strobe towards one block, block number already stripped
	typedef struct packed {
		logic we;
		logic re;
		logic [lpCsrAdrsWidth-1:0] csrAdrs;
		logic [lpUsiBusWidth-1:0] wd;
	} usiSlvReqT;

endpackage

`default_nettype wire
